/* vlog.f */
+incdir+hdl
hdl/servo_hle_pkg.sv
hdl/servo_cmd_decode.sv
hdl/servo_seq_exec.sv
hdl/servo_reply_rom.sv
hdl/servo_hle.sv
verification/servo_hle_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
		--top-module servo_hle_tb -Mdir obj_dir -o servo_hle_sim
	./obj_dir/servo_hle_sim

clean:
	rm -rf obj_dir

/* verification/servo_hle_tb.sv */
`timescale 1ns/1ps

`include "servo_hle_defines.svh"

module servo_hle_tb;

    import servo_hle_pkg::*;

    localparam int run_cycles     = 40000;
    // One eighth of margin over the stimulus length
    localparam int timeout_cycles = run_cycles + run_cycles / 8;

    localparam spi_byte_t release_row [5] = '{8'hbb, 8'ha3, 8'h41, 8'h00, 8'h00};
    localparam spi_byte_t ident0_row  [5] = '{8'hab, 8'haa, 8'h02, 8'h00, 8'h00};
    localparam spi_byte_t ident1_row  [5] = '{8'hab, 8'hb0, 8'h00, 8'h00, 8'h02};
    localparam spi_byte_t ident2_row  [5] = '{8'hab, 8'hb0, 8'h00, 8'h00, 8'h11};
    localparam spi_byte_t ident3_row  [5] = '{8'hab, 8'hb0, 8'h00, 8'h00, 8'h0b};
    localparam spi_byte_t head_row    [5] = '{8'h61, 8'h01, 8'h01, 8'hff, 8'hff};
    localparam spi_byte_t body_row    [5] = '{8'h03, 8'hb0, 8'h00, 8'h00, 8'h0b};

    logic      clk;
    logic      rst;
    logic      write;
    spi_byte_t mosi;
    spi_byte_t miso;
    logic      mode_fault;

    integer seed;
    int     cycle_count = 0;
    int     seq_count;
    int     fault_count;
    int     long_gap_count;

    // Model of the servo script position
    script_e    m_script;
    frame_idx_t m_idx;
    holdoff_t   m_holdoff;
    logic       m_fault;
    opcode_e    m_op;
    spi_byte_t  m_reply;
    // Host leaves the bus alone until the frame gap has run out
    logic       quiet;

    servo_hle i_dut (
        .clk        (clk),
        .rst        (rst),
        .write      (write),
        .mosi       (mosi),
        .miso       (miso),
        .mode_fault (mode_fault)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Run did not finish within %0d cycles", timeout_cycles);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic frame_idx_t frame_bytes(script_e s);
        if (s == scr_idle) begin
            return 3'd0;
        end else if (s == scr_b0_head) begin
            return 3'd3;
        end
        return 3'd5;
    endfunction

    function automatic script_e following_script(script_e s);
        case (s)
            scr_release: return scr_ident0;
            scr_ident0:  return scr_ident1;
            scr_ident1:  return scr_ident2;
            scr_ident2:  return scr_ident3;
            scr_b0_head: return scr_b0_body;
            default:     return scr_idle;
        endcase
    endfunction

    function automatic opcode_e classify(logic wr, spi_byte_t b, script_e s, frame_idx_t i);
        opcode_e op;
        op = op_none;
        if (wr && s == scr_idle) begin
            if (b == 8'hdd) begin
                op = op_release_req;
            end else if (b == 8'hb0) begin
                op = op_b0_req;
            end
        end else if (wr && i < frame_bytes(s)) begin
            if (s == scr_b0_head) begin
                op = op_data;
            end else if (b == 8'haa) begin
                op = op_poll;
            end
        end
        return op;
    endfunction

    function automatic spi_byte_t expected_reply(opcode_e op, script_e s, frame_idx_t i);
        spi_byte_t row [5];
        case (s)
            scr_release: row = release_row;
            scr_ident0:  row = ident0_row;
            scr_ident1:  row = ident1_row;
            scr_ident2:  row = ident2_row;
            scr_ident3:  row = ident3_row;
            scr_b0_head: row = head_row;
            default:     row = body_row;
        endcase
        if (op == op_none) begin
            return 8'hff;
        end else if (op == op_release_req) begin
            return 8'hee;
        end else if (op == op_b0_req) begin
            return 8'h55;
        end
        return row[i];
    endfunction

    task automatic check_miso(spi_byte_t expected);
        if (miso !== expected) begin
            $display("ERROR: miso is %h, expected %h (script %s, index %0d)",
                     miso, expected, m_script.name(), m_idx);
            $display("sim failed");
            $fatal(1, "miso mismatch");
        end
    endtask

    task automatic check_mode_fault(logic expected);
        if (mode_fault !== expected) begin
            $display("ERROR: mode_fault is %h, expected %h (hold-off %h)",
                     mode_fault, expected, m_holdoff);
            $display("sim failed");
            $fatal(1, "mode_fault mismatch");
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] rnd;
        logic [3:0]  pick;
        rnd = $random(seed);
        pick = rnd[11:8];
        if (quiet && m_holdoff == '0) begin
            quiet = 1'b0;
        end
        write = (rnd[2:0] == 3'd0) && !quiet;
        // Mostly polls, then the two start requests, then noise
        if (pick < 4'd8) begin
            mosi = `SERVO_POLL;
        end else if (pick < 4'd11) begin
            mosi = `SERVO_REQ_RELEASE;
        end else if (pick < 4'd13) begin
            mosi = `SERVO_REQ_B0;
        end else begin
            mosi = rnd[23:16];
        end
    endtask

    // Advances the model by one clock edge
    task automatic step_model();
        logic [31:0] rnd;
        logic        gap_done;
        logic        next_fault;
        rnd = $random(seed);
        next_fault = (m_holdoff == 15'd1);
        gap_done = (m_script != scr_idle) && (m_idx == frame_bytes(m_script))
                   && (m_holdoff == '0);
        case (m_op)
            op_release_req: begin
                m_script = scr_release;
                m_idx = '0;
                m_holdoff = 15'h2ff;
                quiet = rnd[4];
                seq_count++;
            end
            op_b0_req: begin
                m_script = scr_b0_head;
                m_idx = '0;
                m_holdoff = 15'd80;
                seq_count++;
            end
            op_poll,
            op_data: begin
                m_idx = m_idx + 3'd1;
                m_holdoff = 15'd80;
            end
            default: begin
                if (gap_done) begin
                    if (m_script == scr_ident1) begin
                        m_holdoff = 15'hfff;
                        long_gap_count++;
                    end else begin
                        m_holdoff = 15'h2ff;
                    end
                    m_script = following_script(m_script);
                    m_idx = '0;
                    quiet = rnd[4];
                end else if (m_holdoff != '0) begin
                    m_holdoff = m_holdoff - 15'd1;
                end
            end
        endcase
        if (next_fault) begin
            fault_count++;
        end
        m_fault = next_fault;
    endtask

    initial begin
        seed = 16;
        seq_count = 0;
        fault_count = 0;
        long_gap_count = 0;
        rst = 1'b1;
        write = 1'b0;
        mosi = '0;
        m_script = scr_idle;
        m_idx = '0;
        m_holdoff = '0;
        m_fault = 1'b0;
        m_op = op_none;
        m_reply = 8'hff;
        quiet = 1'b0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < run_cycles; n++) begin
            check_mode_fault(m_fault);
            drive_inputs();
            // Reply is combinational, so look once the new byte has settled
            #5;
            m_op = classify(write, mosi, m_script, m_idx);
            m_reply = expected_reply(m_op, m_script, m_idx);
            check_miso(m_reply);
            step_model();
            @(negedge clk);
        end

        if (seq_count == 0 || fault_count == 0 || long_gap_count == 0) begin
            $display("Stimulus never reached a script start, a mode_fault pulse or the long gap");
            $display("sim failed");
            $fatal(1, "stimulus did not reach every behavior");
        end else begin
            $display("%0d script starts, %0d mode_fault pulses, %0d long gaps",
                     seq_count, fault_count, long_gap_count);
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* hdl/servo_hle.sv */
`timescale 1ns/1ps

module servo_hle (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     write,
    input  servo_hle_pkg::spi_byte_t mosi,
    output servo_hle_pkg::spi_byte_t miso,
    output logic                     mode_fault
);

    import servo_hle_pkg::*;

    opcode_e    opcode;
    script_e    script;
    frame_idx_t frame_idx;

    servo_cmd_decode i_decode (
        .write     (write),
        .mosi      (mosi),
        .script    (script),
        .frame_idx (frame_idx),
        .opcode    (opcode)
    );

    servo_seq_exec i_exec (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .script     (script),
        .frame_idx  (frame_idx),
        .mode_fault (mode_fault)
    );

    // Reply follows the byte in the same cycle
    servo_reply_rom i_reply (
        .opcode    (opcode),
        .script    (script),
        .frame_idx (frame_idx),
        .miso      (miso)
    );

endmodule

/* hdl/servo_reply_rom.sv */
`timescale 1ns/1ps

`include "servo_hle_defines.svh"

module servo_reply_rom (
    input  servo_hle_pkg::opcode_e    opcode,
    input  servo_hle_pkg::script_e    script,
    input  servo_hle_pkg::frame_idx_t frame_idx,
    output servo_hle_pkg::spi_byte_t  miso
);

    import servo_hle_pkg::*;

    spi_byte_t table_byte;

    // Reply tables, one row per script
    always_comb begin
        table_byte = `SERVO_IDLE_BYTE;

        case (script)
            scr_release: begin
                case (frame_idx)
                    3'd0:    table_byte = 8'hbb;
                    3'd1:    table_byte = 8'ha3;
                    3'd2:    table_byte = 8'h41;
                    3'd3:    table_byte = 8'h00;
                    3'd4:    table_byte = 8'h00;
                    default: table_byte = `SERVO_IDLE_BYTE;
                endcase
            end

            scr_ident0: begin
                case (frame_idx)
                    3'd0:    table_byte = 8'hab;
                    3'd1:    table_byte = 8'haa;
                    3'd2:    table_byte = 8'h02;
                    3'd3:    table_byte = 8'h00;
                    3'd4:    table_byte = 8'h00;
                    default: table_byte = `SERVO_IDLE_BYTE;
                endcase
            end

            // ident1 to ident3 differ in the last byte only
            scr_ident1,
            scr_ident2,
            scr_ident3: begin
                case (frame_idx)
                    3'd0:    table_byte = 8'hab;
                    3'd1:    table_byte = 8'hb0;
                    3'd2:    table_byte = 8'h00;
                    3'd3:    table_byte = 8'h00;
                    3'd4: begin
                        if (script == scr_ident1) begin
                            table_byte = 8'h02;
                        end else if (script == scr_ident2) begin
                            table_byte = 8'h11;
                        end else begin
                            table_byte = 8'h0b;
                        end
                    end
                    default: table_byte = `SERVO_IDLE_BYTE;
                endcase
            end

            scr_b0_head: begin
                case (frame_idx)
                    3'd0:    table_byte = 8'h61;
                    3'd1:    table_byte = 8'h01;
                    3'd2:    table_byte = 8'h01;
                    default: table_byte = `SERVO_IDLE_BYTE;
                endcase
            end

            scr_b0_body: begin
                case (frame_idx)
                    3'd0:    table_byte = 8'h03;
                    3'd1:    table_byte = 8'hb0;
                    3'd2:    table_byte = 8'h00;
                    3'd3:    table_byte = 8'h00;
                    3'd4:    table_byte = 8'h0b;
                    default: table_byte = `SERVO_IDLE_BYTE;
                endcase
            end

            default: table_byte = `SERVO_IDLE_BYTE;
        endcase
    end

    // Start requests have fixed answers, rejected cycles read as idle line
    always_comb begin
        case (opcode)
            op_none:        miso = `SERVO_IDLE_BYTE;
            op_release_req: miso = 8'hee;
            op_b0_req:      miso = 8'h55;
            default:        miso = table_byte;
        endcase
    end

endmodule

/* hdl/servo_seq_exec.sv */
`timescale 1ns/1ps

`include "servo_hle_defines.svh"

module servo_seq_exec (
    input  logic                      clk,
    input  logic                      rst,
    input  servo_hle_pkg::opcode_e    opcode,
    output servo_hle_pkg::script_e    script,
    output servo_hle_pkg::frame_idx_t frame_idx,
    output logic                      mode_fault
);

    import servo_hle_pkg::*;

    holdoff_t holdoff;
    logic     gap_slot;
    logic     gap_done;
    script_e  script_next;
    holdoff_t gap_len;

    assign gap_slot = (script != scr_idle) && (frame_idx == frame_len(script));
    assign gap_done = gap_slot && (holdoff == '0);

    // Order in which the scripts follow each other
    always_comb begin
        case (script)
            scr_release: script_next = scr_ident0;
            scr_ident0:  script_next = scr_ident1;
            scr_ident1:  script_next = scr_ident2;
            scr_ident2:  script_next = scr_ident3;
            scr_ident3:  script_next = scr_idle;
            scr_b0_head: script_next = scr_b0_body;
            scr_b0_body: script_next = scr_idle;
            default:     script_next = scr_idle;
        endcase
    end

    // The servo takes longer after the second ident frame
    always_comb begin
        if (script == scr_ident1) begin
            gap_len = `SERVO_LONG_GAP;
        end else begin
            gap_len = `SERVO_FRAME_GAP;
        end
    end

    // Script position
    always_ff @(posedge clk) begin
        if (rst) begin
            script    <= scr_idle;
            frame_idx <= '0;
        end else begin
            case (opcode)
                op_release_req: begin
                    script    <= scr_release;
                    frame_idx <= '0;
                end

                op_b0_req: begin
                    script    <= scr_b0_head;
                    frame_idx <= '0;
                end

                // Last byte of a frame lands on the gap slot
                op_poll,
                op_data: begin
                    frame_idx <= frame_idx + 3'd1;
                end

                default: begin
                    if (gap_done) begin
                        script    <= script_next;
                        frame_idx <= '0;
                    end
                end
            endcase
        end
    end

    // Hold-off counter
    always_ff @(posedge clk) begin
        if (rst) begin
            holdoff <= '0;
        end else begin
            case (opcode)
                op_release_req: begin
                    holdoff <= `SERVO_FRAME_GAP;
                end

                op_b0_req,
                op_poll,
                op_data: begin
                    holdoff <= `SERVO_BYTE_GAP;
                end

                default: begin
                    if (gap_done) begin
                        holdoff <= gap_len;
                    end else if (holdoff != '0) begin
                        holdoff <= holdoff - 15'd1;
                    end
                end
            endcase
        end
    end

    // Pulse one cycle after the counter sat at one
    always_ff @(posedge clk) begin
        if (rst) begin
            mode_fault <= 1'b0;
        end else begin
            mode_fault <= (holdoff == 15'd1);
        end
    end

endmodule

/* hdl/servo_cmd_decode.sv */
`timescale 1ns/1ps

`include "servo_hle_defines.svh"

module servo_cmd_decode (
    input  logic                     write,
    input  servo_hle_pkg::spi_byte_t  mosi,
    input  servo_hle_pkg::script_e    script,
    input  servo_hle_pkg::frame_idx_t frame_idx,
    output servo_hle_pkg::opcode_e    opcode
);

    import servo_hle_pkg::*;

    logic in_frame;

    // Gap slot sits at frame_idx == frame length and takes nothing
    assign in_frame = frame_idx < frame_len(script);

    always_comb begin
        opcode = op_none;

        if (write) begin
            case (script)
                // Only the two start requests open a script
                scr_idle: begin
                    if (mosi == `SERVO_REQ_RELEASE) begin
                        opcode = op_release_req;
                    end else if (mosi == `SERVO_REQ_B0) begin
                        opcode = op_b0_req;
                    end
                end

                // Header frame answers whatever the host clocks in
                scr_b0_head: begin
                    if (in_frame) begin
                        opcode = op_data;
                    end
                end

                // Release, ident and B0 body frames are polled
                scr_release,
                scr_ident0,
                scr_ident1,
                scr_ident2,
                scr_ident3,
                scr_b0_body: begin
                    if (in_frame && mosi == `SERVO_POLL) begin
                        opcode = op_poll;
                    end
                end

                default: begin
                    opcode = op_none;
                end
            endcase
        end
    end

endmodule

/* hdl/servo_hle_pkg.sv */
`include "servo_hle_defines.svh"

package servo_hle_pkg;

    typedef logic [7:0]  spi_byte_t;
    typedef logic [14:0] holdoff_t;
    typedef logic [2:0]  frame_idx_t;

    typedef enum logic [2:0] {
        scr_idle,
        scr_release,
        scr_ident0,
        scr_ident1,
        scr_ident2,
        scr_ident3,
        scr_b0_head,
        scr_b0_body
    } script_e;

    typedef enum logic [2:0] {
        op_none,
        op_release_req,
        op_b0_req,
        op_poll,
        op_data
    } opcode_e;

    // Number of byte slots in the frame of a script, idle has none
    function automatic frame_idx_t frame_len(script_e script);
        case (script)
            scr_idle:    frame_len = 3'd0;
            scr_b0_head: frame_len = `SERVO_HEAD_LEN;
            default:     frame_len = `SERVO_POLL_LEN;
        endcase
    endfunction

endpackage

/* hdl/servo_hle_defines.svh */
`ifndef SERVO_HLE_DEFINES_SVH
`define SERVO_HLE_DEFINES_SVH

// Hold-off lengths in clock cycles
`define SERVO_BYTE_GAP      15'd80
`define SERVO_FRAME_GAP     15'h2ff
`define SERVO_LONG_GAP      15'hfff

// Request codes sent by the host
`define SERVO_REQ_RELEASE   8'hdd
`define SERVO_REQ_B0        8'hb0
`define SERVO_POLL          8'haa

// Reply when no byte is taken
`define SERVO_IDLE_BYTE     8'hff

// Frame lengths in bytes
`define SERVO_POLL_LEN      3'd5
`define SERVO_HEAD_LEN      3'd3

`endif
